// File: rtl/proc_pkg.sv
// Shared widths, opcodes, ALU codes, FSM states and request structs for the processor RTL
package proc_pkg;

    typedef logic [7:0] word_t;     // Data and register value
    typedef logic [7:0] addr_t;     // Byte address into the 256-byte memory
    typedef logic [1:0] reg_sel_t;  // r0 to r3
    typedef logic [3:0] opcode_t;   // ir[7:4]
    typedef logic [1:0] alu_op_t;

    // Instruction set
    localparam opcode_t NOP   = 4'b0000;
    localparam opcode_t ADD   = 4'b0001;
    localparam opcode_t ADDI  = 4'b0010;
    localparam opcode_t SUB   = 4'b0011;
    localparam opcode_t NEG   = 4'b0110;
    localparam opcode_t BGEZ0 = 4'b1000;
    localparam opcode_t BGEZ1 = 4'b1001;
    localparam opcode_t MOVE  = 4'b1010;
    localparam opcode_t STORE = 4'b1011;
    localparam opcode_t LOAD  = 4'b1100;
    localparam opcode_t LOADI = 4'b1101;
    localparam opcode_t JUMP  = 4'b1110;

    // Low field of NOP that stops the machine
    localparam logic [3:0] HALT_SUB = 4'b1111;

    // r0 ALU operations
    localparam alu_op_t ALU_ADD = 2'd0;
    localparam alu_op_t ALU_SUB = 2'd1;
    localparam alu_op_t ALU_NEG = 2'd3;

    // Branch targets land in program space
    localparam addr_t BRANCH_BASE = 8'd64;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_EXEC,
        ST_ALU,
        ST_MEM,
        ST_HALT
    } cpu_state_e;

    // Memory request whose en is held until ready
    typedef struct packed {
        logic  en;
        logic  we;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    // r0 ALU request whose en is held until ready
    typedef struct packed {
        logic    en;
        alu_op_t op;
        word_t   a;
        word_t   b;
    } alu_req_t;

endpackage

// File: rtl/register_file.sv
// Four user registers r0 to r3; two combinational read ports and one write port
module register_file (
    input  logic               clk,
    input  logic               rst_n,
    input  proc_pkg::reg_sel_t rd_a,
    input  proc_pkg::reg_sel_t rd_b,
    output proc_pkg::word_t    val_a,
    output proc_pkg::word_t    val_b,
    input  logic               wr_en,
    input  proc_pkg::reg_sel_t wr_sel,
    input  proc_pkg::word_t    wr_data
);
    import proc_pkg::*;

    word_t regs [4];

    assign val_a = regs[rd_a];
    assign val_b = regs[rd_b];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_sel] <= wr_data;
        end
    end

endmodule

// File: rtl/r0_alu.sv
// Registered add/sub/negate unit for r0 results; ready pulses one clock after en
module r0_alu (
    input  logic               clk,
    input  logic               rst_n,
    input  proc_pkg::alu_req_t alu_req,
    output proc_pkg::word_t    alu_result,
    output logic               alu_ready
);
    import proc_pkg::*;

    word_t result_d;
    logic  start;

    // No restart on the ready cycle while en is still held
    assign start = alu_req.en && !alu_ready;

    always_comb begin
        case (alu_req.op)
            ALU_ADD: result_d = alu_req.a + alu_req.b;
            ALU_SUB: result_d = alu_req.a - alu_req.b;
            ALU_NEG: result_d = 8'd0 - alu_req.a;
            default: result_d = alu_req.a;  // Unused code passes a
        endcase
    end

    always_ff @(posedge clk) begin
        if (start) begin
            alu_result <= result_d;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_ready <= 1'b0;
        end else begin
            alu_ready <= start;
        end
    end

endmodule

// File: rtl/memory_controller.sv
// 256-byte shared program/data memory; arbitrates fetch, data and host writes, plus a peek port
module memory_controller (
    input  logic               clk,
    input  logic               rst_n,
    input  proc_pkg::mem_req_t fetch_req,
    input  proc_pkg::mem_req_t data_req,
    input  proc_pkg::mem_req_t host_req,
    input  logic               busy,
    output logic               ready,
    output proc_pkg::word_t    rdata,
    input  proc_pkg::addr_t    peek_addr,
    output proc_pkg::word_t    peek_data
);
    import proc_pkg::*;

    word_t    mem [256];
    mem_req_t sel;
    logic     start;
    logic     host_wr;

    assign sel   = fetch_req.en ? fetch_req : data_req;  // Fetch wins
    assign start = sel.en && !ready;

    // Host only loads while the CPU is stopped
    assign host_wr = host_req.en && host_req.we && !busy;

    always_ff @(posedge clk) begin
        if (start) begin
            if (sel.we) begin
                mem[sel.addr] <= sel.wdata;
            end
            rdata <= mem[sel.addr];
        end else if (host_wr) begin
            mem[host_req.addr] <= host_req.wdata;
        end
    end

    always_ff @(posedge clk) begin
        peek_data <= mem[peek_addr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready <= 1'b0;
        end else begin
            ready <= start;  // One pulse per request
        end
    end

endmodule

// File: rtl/control_unit.sv
// Fetch/execute FSM; holds pc, ir and the retired count and sequences every instruction
module control_unit #(
    parameter proc_pkg::addr_t RESET_PC = 8'd64
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,
    output proc_pkg::mem_req_t  fetch_req,
    output proc_pkg::mem_req_t  data_req,
    input  logic                mem_ready,
    input  proc_pkg::word_t     mem_rdata,
    output proc_pkg::alu_req_t  alu_req,
    input  logic                alu_ready,
    input  proc_pkg::word_t     alu_result,
    output proc_pkg::reg_sel_t  rd_a,
    output proc_pkg::reg_sel_t  rd_b,
    input  proc_pkg::word_t     val_a,
    input  proc_pkg::word_t     val_b,
    output logic                wr_en,
    output proc_pkg::reg_sel_t  wr_sel,
    output proc_pkg::word_t     wr_data,
    output logic                busy,
    output logic                halt,
    output logic [15:0]         cc
);
    import proc_pkg::*;

    cpu_state_e state;
    addr_t      pc;
    word_t      ir;

    opcode_t    op;
    reg_sel_t   field_a;
    reg_sel_t   field_b;
    addr_t      pc_inc;
    addr_t      branch_target;
    addr_t      next_pc;
    logic       is_alu_op;
    logic       is_mem_op;
    logic       is_halt;
    logic       retire;

    assign op      = ir[7:4];
    assign field_a = ir[3:2];
    assign field_b = ir[1:0];
    assign pc_inc  = pc + 8'd1;

    // BGEZ1 reaches the upper half of the branch window
    assign branch_target = BRANCH_BASE + {2'b00, op[0], ir[3:0], 1'b0};

    assign is_alu_op = (op == ADD) || (op == SUB) || (op == NEG);
    assign is_mem_op = (op == LOAD) || (op == STORE);
    assign is_halt   = (op == NOP) && (ir[3:0] == HALT_SUB);

    assign halt = (state == ST_HALT);
    assign busy = (state != ST_IDLE) && (state != ST_HALT);  // Host port owns memory otherwise

    // Single-cycle ops retire in EXEC, the rest on their ready pulse
    assign retire = ((state == ST_EXEC) && !is_alu_op && !is_mem_op)
                 || ((state == ST_ALU) && alu_ready)
                 || ((state == ST_MEM) && mem_ready);

    // Read port A is rerouted for the ops with a fixed source
    always_comb begin
        case (op)
            BGEZ0, BGEZ1: rd_a = 2'd0;  // Condition on r0
            LOAD:         rd_a = 2'd3;  // Page bits from r3
            default:      rd_a = field_a;
        endcase
        rd_b = field_b;
    end

    always_comb begin
        case (op)
            BGEZ0, BGEZ1: next_pc = val_a[7] ? pc_inc : branch_target;  // Signed r0 >= 0
            JUMP:         next_pc = val_a;
            default:      next_pc = pc_inc;
        endcase
    end

    always_comb begin
        fetch_req.en    = (state == ST_FETCH);
        fetch_req.we    = 1'b0;
        fetch_req.addr  = pc;
        fetch_req.wdata = '0;

        data_req.en    = ((state == ST_EXEC) && is_mem_op) || (state == ST_MEM);
        data_req.we    = (op == STORE);
        data_req.addr  = (op == LOAD) ? {2'b00, val_a[1:0], ir[3:0]} : val_a;
        data_req.wdata = val_b;
    end

    always_comb begin
        alu_req.en = ((state == ST_EXEC) && is_alu_op) || (state == ST_ALU);
        case (op)
            SUB:     alu_req.op = ALU_SUB;
            NEG:     alu_req.op = ALU_NEG;
            default: alu_req.op = ALU_ADD;
        endcase
        alu_req.a = val_a;
        alu_req.b = val_b;
    end

    // Register writeback
    always_comb begin
        wr_en   = 1'b0;
        wr_sel  = field_a;
        wr_data = val_b;
        case (state)
            ST_EXEC: begin
                case (op)
                    ADDI: begin
                        wr_en   = 1'b1;
                        wr_data = val_a + {6'b0, field_b};
                    end
                    MOVE: wr_en = 1'b1;
                    LOADI: begin
                        wr_en   = 1'b1;
                        wr_data = {6'b0, field_b};
                    end
                    JUMP: begin
                        wr_en   = 1'b1;  // Link into r3 after val_a gave the target
                        wr_sel  = 2'd3;
                        wr_data = pc_inc;
                    end
                    default: wr_en = 1'b0;
                endcase
            end
            ST_ALU: begin
                wr_en   = alu_ready;
                wr_sel  = 2'd0;
                wr_data = alu_result;
            end
            ST_MEM: begin
                wr_en   = mem_ready && (op == LOAD);
                wr_sel  = 2'd0;
                wr_data = mem_rdata;
            end
            default: wr_en = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            pc    <= '0;
            ir    <= '0;
            cc    <= '0;
        end else begin
            if (retire) begin
                cc <= cc + 16'd1;
            end
            case (state)
                ST_IDLE: begin
                    if (en) begin
                        pc    <= RESET_PC;
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (mem_ready) begin
                        ir    <= mem_rdata;
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (is_alu_op) begin
                        state <= ST_ALU;
                    end else if (is_mem_op) begin
                        state <= ST_MEM;
                    end else if (is_halt) begin
                        state <= ST_HALT;
                    end else begin
                        pc    <= next_pc;
                        state <= ST_FETCH;
                    end
                end
                ST_ALU: begin
                    if (alu_ready) begin
                        pc    <= pc_inc;
                        state <= ST_FETCH;
                    end
                end
                ST_MEM: begin
                    if (mem_ready) begin
                        pc    <= pc_inc;
                        state <= ST_FETCH;
                    end
                end
                default: ;  // ST_HALT holds until reset
            endcase
        end
    end

endmodule

// File: rtl/processor_top.sv
// Processor top level; connect en, host load port and peek port, then wait for halt
module processor_top #(
    parameter proc_pkg::addr_t RESET_PC = 8'd64
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  proc_pkg::mem_req_t host_req,
    input  proc_pkg::addr_t    peek_addr,
    output proc_pkg::word_t    peek_data,
    output logic               halt,
    output logic [15:0]        cc
);
    import proc_pkg::*;

    mem_req_t fetch_req;
    mem_req_t data_req;
    logic     mem_ready;
    word_t    mem_rdata;
    logic     busy;

    alu_req_t alu_req;
    logic     alu_ready;
    word_t    alu_result;

    reg_sel_t rd_a;
    reg_sel_t rd_b;
    word_t    val_a;
    word_t    val_b;
    logic     wr_en;
    reg_sel_t wr_sel;
    word_t    wr_data;

    control_unit #(
        .RESET_PC (RESET_PC)
    ) i_control_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .fetch_req  (fetch_req),
        .data_req   (data_req),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .alu_req    (alu_req),
        .alu_ready  (alu_ready),
        .alu_result (alu_result),
        .rd_a       (rd_a),
        .rd_b       (rd_b),
        .val_a      (val_a),
        .val_b      (val_b),
        .wr_en      (wr_en),
        .wr_sel     (wr_sel),
        .wr_data    (wr_data),
        .busy       (busy),
        .halt       (halt),
        .cc         (cc)
    );

    register_file i_register_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_a    (rd_a),
        .rd_b    (rd_b),
        .val_a   (val_a),
        .val_b   (val_b),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_data (wr_data)
    );

    r0_alu i_r0_alu (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_req    (alu_req),
        .alu_result (alu_result),
        .alu_ready  (alu_ready)
    );

    memory_controller i_memory_controller (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .data_req  (data_req),
        .host_req  (host_req),
        .busy      (busy),
        .ready     (mem_ready),
        .rdata     (mem_rdata),
        .peek_addr (peek_addr),
        .peek_data (peek_data)
    );

endmodule

// File: tb/tb_programs.svh
// Instruction encoders and test programs; included in tb_processor, select_program fills prog
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

localparam reg_sel_t R0 = 2'd0;
localparam reg_sel_t R1 = 2'd1;
localparam reg_sel_t R2 = 2'd2;
localparam reg_sel_t R3 = 2'd3;
localparam word_t    HALT_I = {NOP, HALT_SUB};

function automatic word_t encode(opcode_t op, reg_sel_t a, reg_sel_t b);
    return {op, a, b};
endfunction

// LOAD offset, branch target and HALT use the whole low nibble
function automatic word_t encode_low(opcode_t op, logic [3:0] low);
    return {op, low};
endfunction

// NOP fill so the next byte lands at addr
function automatic void pad_to(int addr);
    while (prog.size() < addr - int'(PROG_BASE)) begin
        prog.push_back(encode_low(NOP, 4'h0));
    end
endfunction

function automatic void select_program(int n);
    case (n)
        0: begin  // Arithmetic, wraparound and paged LOAD
            prog = {encode(LOADI, R1, 2'd3), encode(ADDI, R1, 2'd2), encode(MOVE, R0, R1),
                    encode(ADD, R1, R0), encode(STORE, R2, R0), encode(ADDI, R2, 2'd1),
                    encode(SUB, R2, R1), encode(STORE, R2, R0), encode(ADDI, R2, 2'd1),
                    encode(NEG, R0, R0), encode(STORE, R2, R0), encode(NEG, R1, R0),
                    encode(ADD, R0, R0), encode(ADDI, R2, 2'd1), encode(STORE, R2, R0),
                    encode(LOADI, R3, 2'd1), encode_low(LOAD, 4'h5), encode(MOVE, R1, R0),
                    encode(LOADI, R3, 2'd2), encode_low(LOAD, 4'ha), encode(ADD, R0, R1),
                    encode(MOVE, R1, R0), encode(LOADI, R3, 2'd3), encode_low(LOAD, 4'hf),
                    encode(ADD, R0, R1), encode(ADDI, R2, 2'd1), encode(STORE, R2, R0),
                    encode(LOADI, R3, 2'd0), encode_low(LOAD, 4'h1), encode(ADDI, R0, 2'd3),
                    encode(ADDI, R0, 2'd3), encode(ADDI, R2, 2'd1), encode(STORE, R2, R0),
                    encode_low(NOP, 4'h0), HALT_I};
        end
        1: begin  // Taken and fall-through branches with marker stores
            prog = {encode(LOADI, R1, 2'd1), encode(LOADI, R0, 2'd2), encode_low(BGEZ0, 4'h4),
                    encode(STORE, R2, R1), HALT_I};
            pad_to(72);
            prog = {prog, encode(LOADI, R1, 2'd2), encode(STORE, R2, R1),
                    encode(ADDI, R2, 2'd1), encode(NEG, R1, R0), encode_low(BGEZ0, 4'h0),
                    encode(LOADI, R1, 2'd3), encode(STORE, R2, R1), encode(ADDI, R2, 2'd1),
                    encode(LOADI, R0, 2'd0), encode_low(BGEZ1, 4'h0), encode(STORE, R2, R2),
                    HALT_I};
            pad_to(96);
            prog = {prog, encode(STORE, R2, R1), encode(ADDI, R2, 2'd1), encode(NEG, R1, R0),
                    encode_low(BGEZ1, 4'h3), encode(STORE, R2, R0), HALT_I,
                    encode(STORE, R2, R2), HALT_I};
        end
        default: begin  // JUMP to 96 built in r1 and link stored from r3
            prog = {encode(LOADI, R1, 2'd3), encode(ADD, R1, R1), encode(MOVE, R1, R0),
                    encode(ADD, R1, R1), encode(MOVE, R1, R0), encode(ADD, R1, R1),
                    encode(MOVE, R2, R0), encode(MOVE, R1, R0), encode(ADD, R1, R1),
                    encode(ADD, R0, R2), encode(ADD, R0, R2), encode(MOVE, R1, R0),
                    encode(LOADI, R2, 2'd0), encode(JUMP, R1, R0), encode(LOADI, R0, 2'd1),
                    encode(STORE, R2, R0), HALT_I};
            pad_to(96);
            prog = {prog, encode(STORE, R2, R3), encode(ADDI, R2, 2'd1),
                    encode(LOADI, R0, 2'd2), encode(STORE, R2, R0), HALT_I};
        end
    endcase
endfunction

`endif

// File: tb/tb_processor.sv
// Testbench for processor_top; loads programs over the host port, runs them, checks memory and cc
module tb_processor;
    import proc_pkg::*;

    localparam addr_t PROG_BASE = 8'd64;
    localparam int    NUM_PROGS = 3;
    localparam int    CYCLES_PER_INSTR = 200;

    logic        clk;
    logic        rst_n;
    logic        en;
    mem_req_t    host_req;
    addr_t       peek_addr;
    word_t       peek_data;
    logic        halt;
    logic [15:0] cc;

    word_t       prog [$];
    word_t       image [256];  // Bytes as loaded
    word_t       model_mem [256];
    logic [15:0] model_cc;
    logic [31:0] lcg_state;
    int          watchdog_cycles;
    logic        halt_seen;
    logic [15:0] cc_at_halt;

    `include "tb_programs.svh"

    processor_top #(.RESET_PC(PROG_BASE)) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .host_req  (host_req),
        .peek_addr (peek_addr),
        .peek_data (peek_data),
        .halt      (halt),
        .cc        (cc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // Instruction-level model of the ISA running on a copy of the loaded image
    task automatic run_model();
        word_t r [4];
        word_t ir;
        addr_t pc;
        addr_t pc_next;
        logic  done;
        int    steps;
        for (int i = 0; i < 4; i++) begin
            r[i] = '0;
        end
        model_mem = image;
        model_cc = '0;
        pc = PROG_BASE;
        done = 1'b0;
        steps = 0;
        while (!done) begin
            ir = model_mem[pc];
            pc_next = pc + 8'd1;
            model_cc = model_cc + 16'd1;
            steps++;
            case (ir[7:4])
                NOP:   done = (ir[3:0] == HALT_SUB);
                ADD:   r[0] = r[ir[3:2]] + r[ir[1:0]];
                SUB:   r[0] = r[ir[3:2]] - r[ir[1:0]];
                NEG:   r[0] = 8'd0 - r[ir[3:2]];
                ADDI:  r[ir[3:2]] = r[ir[3:2]] + {6'd0, ir[1:0]};
                MOVE:  r[ir[3:2]] = r[ir[1:0]];
                LOADI: r[ir[3:2]] = {6'd0, ir[1:0]};
                LOAD:  r[0] = model_mem[{2'b00, r[3][1:0], ir[3:0]}];
                STORE: model_mem[r[ir[3:2]]] = r[ir[1:0]];
                BGEZ0, BGEZ1: begin
                    if (!r[0][7]) begin
                        pc_next = BRANCH_BASE + {2'b00, ir[4], ir[3:0], 1'b0};
                    end
                end
                JUMP: begin
                    pc_next = r[ir[3:2]];  // Target read before the link
                    r[3] = pc + 8'd1;
                end
                default: ;
            endcase
            pc = pc_next;
            if (steps > 4096) begin
                $display("reference model did not reach HALT");
                stop_with_failure();
            end
        end
    endtask

    task automatic run_program(input int n);
        select_program(n);
        for (int a = 0; a < 256; a++) begin
            lcg_state = lcg_next(lcg_state);
            image[a] = lcg_state[23:16];
        end
        foreach (prog[i]) begin
            image[int'(PROG_BASE) + i] = prog[i];
        end
        @(posedge clk);
        rst_n <= 1'b0;
        en <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int a = 0; a < 256; a++) begin
            @(posedge clk);
            host_req <= '{en: 1'b1, we: 1'b1, addr: addr_t'(a), wdata: image[a]};
        end
        @(posedge clk);
        host_req <= '0;
        repeat (4) @(posedge clk);  // Idle with en low
        en <= 1'b1;
        do @(negedge clk); while (!halt);
        repeat (5) @(negedge clk);
        run_model();
        assert (cc === model_cc) else begin
            $display("mismatch cc: got %h expected %h", cc, model_cc);
            stop_with_failure();
        end
        for (int a = 0; a < 256; a++) begin
            @(posedge clk);
            peek_addr <= addr_t'(a);
            @(posedge clk);
            @(negedge clk);
            assert (peek_data === model_mem[a]) else begin
                $display("mismatch peek_data at %h: got %h expected %h",
                         addr_t'(a), peek_data, model_mem[a]);
                stop_with_failure();
            end
        end
    endtask

    // Idle outputs before start, sticky halt and frozen cc after it
    always @(negedge clk) begin
        if (!rst_n) begin
            halt_seen = 1'b0;
        end else begin
            if (!en) begin
                assert (halt === 1'b0) else begin
                    $display("mismatch halt before start: got %h expected %h", halt, 1'b0);
                    stop_with_failure();
                end
                assert (cc === 16'd0) else begin
                    $display("mismatch cc before start: got %h expected %h", cc, 16'd0);
                    stop_with_failure();
                end
            end
            if (halt_seen) begin
                assert (halt === 1'b1) else begin
                    $display("mismatch halt after HALT: got %h expected %h", halt, 1'b1);
                    stop_with_failure();
                end
                assert (cc === cc_at_halt) else begin
                    $display("mismatch cc after HALT: got %h expected %h", cc, cc_at_halt);
                    stop_with_failure();
                end
            end else if (halt === 1'b1) begin
                halt_seen = 1'b1;
                cc_at_halt = cc;
            end
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired before all programs finished");
        stop_with_failure();
    end

    initial begin
        rst_n <= 1'b0;
        en <= 1'b0;
        host_req <= '0;
        peek_addr <= '0;
        lcg_state = 32'hf2e7;
        // Budget covers execution plus load and peek passes
        for (int n = 0; n < NUM_PROGS; n++) begin
            select_program(n);
            watchdog_cycles += prog.size() * CYCLES_PER_INSTR + 4 * 256 + 64;
        end
        for (int n = 0; n < NUM_PROGS; n++) begin
            run_program(n);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+tb
rtl/proc_pkg.sv
rtl/register_file.sv
rtl/r0_alu.sv
rtl/memory_controller.sv
rtl/control_unit.sv
rtl/processor_top.sv
tb/tb_processor.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_processor -f vlog.f || exit 1
out=$(./obj_dir/Vtb_processor)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
